// ==== project.f ====
rtl/corePkg.sv
rtl/instDecoder.sv
rtl/immGen.sv
rtl/regFile.sv
rtl/alu.sv
rtl/csrFile.sv
rtl/loadStoreUnit.sv
rtl/riscvCore.sv
sim/coreTb.sv

// ==== rtl/alu.sv ====
`default_nettype none

module alu (
    input  corePkg::aluOpT op,
    input  logic [63:0]    a,
    input  logic [63:0]    b,
    input  logic           rs1to32,
    output logic [63:0]    result
);
    import corePkg::*;

    logic [63:0] opA;
    logic [5:0]  shamt;

    // word shifts work on the low half of a
    always_comb begin
        opA = a;
        shamt = b[5:0];
        if (rs1to32) begin
            if (op == ALU_SRA) begin
                opA = {{32{a[31]}}, a[31:0]};
            end else begin
                opA = {32'd0, a[31:0]};
            end
            shamt = {1'b0, b[4:0]};
        end
    end

    always_comb begin
        case (op)
            ALU_ADD:      result = opA + b;
            ALU_SUB:      result = opA - b;
            ALU_SLL:      result = opA << shamt;
            ALU_SRL:      result = opA >> shamt;
            ALU_SRA:      result = $signed(opA) >>> shamt;
            ALU_SLT:      result = {63'd0, $signed(opA) < $signed(b)};
            ALU_SLTU:     result = {63'd0, opA < b};
            ALU_XOR:      result = opA ^ b;
            ALU_OR:       result = opA | b;
            ALU_AND:      result = opA & b;
            ALU_RETURN_A: result = opA;
            ALU_RETURN_B: result = b;
            default:      result = 64'd0;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/corePkg.sv ====
`default_nettype none

package corePkg;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_OR, ALU_AND, ALU_RETURN_A, ALU_RETURN_B, ALU_NONE
    } aluOpT;

    typedef enum logic [2:0] {
        WB_ALU    = 3'b000,
        WB_LOAD   = 3'b001,
        WB_PC4    = 3'b010,
        WB_SEXT32 = 3'b100, // low word of alu result, sign-extended
        WB_CSR    = 3'b101
    } wbSelT;

    typedef enum logic [1:0] {OPA_PC = 2'b00, OPA_RS1 = 2'b01} opASelT;
    typedef enum logic [1:0] {OPB_IMM = 2'b00, OPB_RS2 = 2'b01, OPB_CSR = 2'b11} opBSelT;

    typedef logic [11:0] csrAddrT;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instFieldsT;

    typedef struct packed {
        logic [11:0] sysImm; // csr address or ecall/ebreak/mret selector
        logic [19:0] rest;
    } instSysT;

    typedef union packed {
        instFieldsT fields;
        instSysT    sys;
    } instWordT;

    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM32  = 7'b0011011;
    localparam logic [6:0] OP_REG32  = 7'b0111011;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    localparam logic [11:0] SYS_ECALL  = 12'h000;
    localparam logic [11:0] SYS_EBREAK = 12'h001;
    localparam logic [11:0] SYS_MRET   = 12'h302;

    localparam csrAddrT CSR_MSTATUS = 12'h300;
    localparam csrAddrT CSR_MTVEC   = 12'h305;
    localparam csrAddrT CSR_MEPC    = 12'h341;
    localparam csrAddrT CSR_MCAUSE  = 12'h342;

endpackage

`default_nettype wire

// ==== rtl/csrFile.sv ====
`default_nettype none

module csrFile (
    input  logic             clk,
    input  logic             rst,
    input  corePkg::csrAddrT csrAddr,
    input  logic             wen,
    input  logic             setBits,
    input  logic [63:0]      writeData,
    input  logic             trap,
    input  logic [63:0]      trapPc,
    output logic [63:0]      readData,
    output logic [63:0]      mtvec,
    output logic [63:0]      mepc
);
    import corePkg::*;

    logic [63:0] mstatus;
    logic [63:0] mcause;
    logic [63:0] newValue;

    always_comb begin
        case (csrAddr)
            CSR_MSTATUS: readData = mstatus;
            CSR_MTVEC:   readData = mtvec;
            CSR_MEPC:    readData = mepc;
            CSR_MCAUSE:  readData = mcause;
            default:     readData = 64'd0;
        endcase
    end

    assign newValue = setBits ? (readData | writeData) : writeData;

    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus <= 64'd0;
            mtvec <= 64'd0;
            mepc <= 64'd0;
            mcause <= 64'd0;
        end else if (trap) begin
            mepc <= trapPc;
            mcause <= 64'd11; // ecall from M mode
            mstatus[7] <= mstatus[3]; // MPIE <= MIE
            mstatus[3] <= 1'b0;
        end else if (wen) begin
            case (csrAddr)
                CSR_MSTATUS: mstatus <= newValue;
                CSR_MTVEC:   mtvec <= newValue;
                CSR_MEPC:    mepc <= newValue;
                CSR_MCAUSE:  mcause <= newValue;
                default: ;
            endcase
        end
    end

    trapNotWrite: assert property (@(posedge clk) disable iff (rst) !(trap && wen));

endmodule

`default_nettype wire

// ==== rtl/immGen.sv ====
`default_nettype none

module immGen (
    input  corePkg::instWordT inst,
    output logic [63:0]       imm
);
    import corePkg::*;

    instFieldsT f;
    logic       sign;

    assign f = inst.fields;
    assign sign = f.funct7[6]; // inst[31] in every format

    always_comb begin
        case (f.opcode)
            OP_STORE: begin
                imm = {{52{sign}}, f.funct7, f.rd};
            end
            OP_BRANCH: begin
                imm = {{51{sign}}, sign, f.rd[0], f.funct7[5:0], f.rd[4:1], 1'b0};
            end
            OP_LUI, OP_AUIPC: begin
                imm = {{32{sign}}, f.funct7, f.rs2, f.rs1, f.funct3, 12'd0};
            end
            OP_JAL: begin
                imm = {{43{sign}}, sign, f.rs1, f.funct3, f.rs2[0], f.funct7[5:0],
                       f.rs2[4:1], 1'b0};
            end
            default: begin
                imm = {{52{sign}}, f.funct7, f.rs2}; // I format
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/instDecoder.sv ====
`default_nettype none

module instDecoder (
    input  corePkg::instWordT inst,
    input  logic [63:0]       rs1Data,
    input  logic [63:0]       rs2Data,
    output corePkg::aluOpT    aluOp,
    output corePkg::opASelT   opASel,
    output corePkg::opBSelT   opBSel,
    output logic              regWen,
    output corePkg::wbSelT    wbSel,
    output logic [3:0]        loadSize,
    output logic              loadSigned,
    output logic [3:0]        storeSize,
    output logic              dataReadEn,
    output logic              rs1to32,
    output logic              csrWen,
    output logic              csrSet,
    output logic              isEcall,
    output logic              isMret,
    output logic              isEbreak,
    output logic              jumpReg,
    output logic              takeTarget
);
    import corePkg::*;

    logic [6:0] funct7;
    logic [2:0] funct3;

    assign funct7 = inst.fields.funct7;
    assign funct3 = inst.fields.funct3;

    // shared op table for reg and imm forms, alt picks sub / sra
    function automatic aluOpT baseOp(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  baseOp = alt ? ALU_SUB : ALU_ADD;
            3'b001:  baseOp = ALU_SLL;
            3'b010:  baseOp = ALU_SLT;
            3'b011:  baseOp = ALU_SLTU;
            3'b100:  baseOp = ALU_XOR;
            3'b101:  baseOp = alt ? ALU_SRA : ALU_SRL;
            3'b110:  baseOp = ALU_OR;
            default: baseOp = ALU_AND;
        endcase
    endfunction

    always_comb begin
        aluOp = ALU_NONE;
        opASel = OPA_RS1;
        opBSel = OPB_IMM;
        regWen = 1'b0;
        wbSel = WB_ALU;
        loadSize = 4'd0;
        loadSigned = 1'b0;
        storeSize = 4'd0;
        dataReadEn = 1'b0;
        rs1to32 = 1'b0;
        csrWen = 1'b0;
        csrSet = 1'b0;
        isEcall = 1'b0;
        isMret = 1'b0;
        isEbreak = 1'b0;
        jumpReg = 1'b0;
        takeTarget = 1'b0;
        case (inst.fields.opcode)
            OP_LUI: begin
                regWen = 1'b1;
                aluOp = ALU_RETURN_B;
            end
            OP_AUIPC: begin
                regWen = 1'b1;
                opASel = OPA_PC;
                aluOp = ALU_ADD;
            end
            OP_JAL: begin
                regWen = 1'b1;
                wbSel = WB_PC4;
                takeTarget = 1'b1;
            end
            OP_JALR: begin
                regWen = 1'b1;
                wbSel = WB_PC4;
                takeTarget = 1'b1;
                jumpReg = 1'b1; // target from rs1
            end
            OP_BRANCH: begin
                case (funct3)
                    3'b000:  takeTarget = rs1Data == rs2Data;
                    3'b001:  takeTarget = rs1Data != rs2Data;
                    3'b100:  takeTarget = $signed(rs1Data) < $signed(rs2Data);
                    3'b101:  takeTarget = $signed(rs1Data) >= $signed(rs2Data);
                    3'b110:  takeTarget = rs1Data < rs2Data;
                    3'b111:  takeTarget = rs1Data >= rs2Data;
                    default: takeTarget = 1'b0;
                endcase
            end
            OP_LOAD: begin
                regWen = 1'b1;
                wbSel = WB_LOAD;
                dataReadEn = 1'b1;
                aluOp = ALU_ADD;
                loadSize = 4'd1 << funct3[1:0]; // 1, 2, 4 or 8 bytes
                loadSigned = !funct3[2];
            end
            OP_STORE: begin
                aluOp = ALU_ADD;
                storeSize = 4'd1 << funct3[1:0];
            end
            OP_IMM: begin
                regWen = 1'b1;
                aluOp = baseOp(funct3, funct3 == 3'b101 && funct7[5]);
            end
            OP_REG: begin
                regWen = 1'b1;
                opBSel = OPB_RS2;
                aluOp = baseOp(funct3, funct7[5]);
            end
            OP_IMM32: begin
                regWen = 1'b1;
                wbSel = WB_SEXT32;
                rs1to32 = funct3[0]; // word shifts only
                aluOp = baseOp(funct3, funct3 == 3'b101 && funct7[5]);
            end
            OP_REG32: begin
                regWen = 1'b1;
                opBSel = OPB_RS2;
                wbSel = WB_SEXT32;
                rs1to32 = funct3[0];
                aluOp = baseOp(funct3, funct7[5]);
            end
            OP_SYSTEM: begin
                case (funct3)
                    3'b000: begin
                        case (inst.sys.sysImm)
                            SYS_ECALL:  isEcall = 1'b1;
                            SYS_EBREAK: isEbreak = 1'b1;
                            SYS_MRET:   isMret = 1'b1;
                            default: ;
                        endcase
                    end
                    3'b001: begin // csrrw
                        regWen = 1'b1;
                        wbSel = WB_CSR;
                        csrWen = 1'b1;
                        aluOp = ALU_RETURN_A;
                    end
                    3'b010: begin // csrrs
                        regWen = 1'b1;
                        wbSel = WB_CSR;
                        csrWen = 1'b1;
                        csrSet = 1'b1;
                        opBSel = OPB_CSR;
                        aluOp = ALU_OR;
                    end
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/loadStoreUnit.sv ====
`default_nettype none

module loadStoreUnit (
    input  logic [63:0] addr,
    input  logic [63:0] storeData,
    input  logic [3:0]  storeSize,
    input  logic [3:0]  loadSize,
    input  logic        loadSigned,
    input  logic [63:0] memReadData,
    output logic [63:0] writeData,
    output logic [7:0]  writeMask,
    output logic [63:0] loadData
);
    logic [5:0]  bitOffset;
    logic [7:0]  sizeMask;
    logic [63:0] shifted;

    assign bitOffset = {addr[2:0], 3'b000};

    always_comb begin
        case (storeSize)
            4'd1:    sizeMask = 8'h01;
            4'd2:    sizeMask = 8'h03;
            4'd4:    sizeMask = 8'h0f;
            4'd8:    sizeMask = 8'hff;
            default: sizeMask = 8'h00;
        endcase
    end

    assign writeMask = sizeMask << addr[2:0];
    assign writeData = storeData << bitOffset; // lanes line up with mask
    assign shifted = memReadData >> bitOffset;

    always_comb begin
        case (loadSize)
            4'd1:    loadData = {{56{loadSigned & shifted[7]}}, shifted[7:0]};
            4'd2:    loadData = {{48{loadSigned & shifted[15]}}, shifted[15:0]};
            4'd4:    loadData = {{32{loadSigned & shifted[31]}}, shifted[31:0]};
            default: loadData = shifted;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/regFile.sv ====
`default_nettype none

module regFile (
    input  logic        clk,
    input  logic        rst,
    input  logic [4:0]  rs1Addr,
    input  logic [4:0]  rs2Addr,
    input  logic [4:0]  rdAddr,
    input  logic        rdWen,
    input  logic [63:0] rdData,
    output logic [63:0] rs1Data,
    output logic [63:0] rs2Data
);
    logic [63:0] regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 64'd0;
            end
        end else if (rdWen && rdAddr != 5'd0) begin
            regs[rdAddr] <= rdData;
        end
    end

    assign rs1Data = (rs1Addr == 5'd0) ? 64'd0 : regs[rs1Addr];
    assign rs2Data = (rs2Addr == 5'd0) ? 64'd0 : regs[rs2Addr];

endmodule

`default_nettype wire

// ==== rtl/riscvCore.sv ====
`default_nettype none

module riscvCore #(
    parameter logic [63:0] RESET_PC = 64'd0
) (
    input  logic        clk,
    input  logic        rst,
    output logic [63:0] instAddr,
    input  logic [31:0] inst,
    output logic [63:0] dataAddr,
    output logic [63:0] dataWriteData,
    output logic [7:0]  dataWriteMask,
    output logic        dataReadEn,
    input  logic [63:0] dataReadData,
    output logic        halted
);
    import corePkg::*;

    instWordT    instWord;
    csrAddrT     csrAddr;
    aluOpT       aluOp;
    opASelT      opASel;
    opBSelT      opBSel;
    wbSelT       wbSel;
    logic [63:0] pc, pcPlus4, target, nextPc, imm;
    logic [63:0] rs1Data, rs2Data, opA, opB, aluResult, loadData, wbData;
    logic [63:0] csrRead, mtvec, mepc;
    logic [3:0]  loadSize, storeSize;
    logic [7:0]  lsuMask;
    logic        regWen, loadSigned, readEn, rs1to32, csrWen, csrSet;
    logic        isEcall, isMret, isEbreak, jumpReg, takeTarget;

    assign instWord = inst;
    assign csrAddr = instWord.sys.sysImm;
    assign instAddr = pc;
    assign pcPlus4 = pc + 64'd4;
    assign target = jumpReg ? ((rs1Data + imm) & ~64'd1) : (pc + imm);

    always_comb begin
        if (isEcall) begin
            nextPc = mtvec;
        end else if (isMret) begin
            nextPc = mepc;
        end else if (takeTarget) begin
            nextPc = target;
        end else begin
            nextPc = pcPlus4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
            halted <= 1'b0;
        end else if (!halted) begin
            if (isEbreak) begin
                halted <= 1'b1; // pc stays on the ebreak
            end else begin
                pc <= nextPc;
            end
        end
    end

    assign opA = (opASel == OPA_PC) ? pc : rs1Data;

    always_comb begin
        case (opBSel)
            OPB_RS2: opB = rs2Data;
            OPB_CSR: opB = csrRead;
            default: opB = imm;
        endcase
    end

    always_comb begin
        case (wbSel)
            WB_LOAD:   wbData = loadData;
            WB_PC4:    wbData = pcPlus4;
            WB_CSR:    wbData = csrRead;
            WB_SEXT32: wbData = {{32{aluResult[31]}}, aluResult[31:0]};
            default:   wbData = aluResult;
        endcase
    end

    assign dataAddr = {aluResult[63:3], 3'b000};
    assign dataWriteMask = halted ? 8'h00 : lsuMask;
    assign dataReadEn = readEn & !halted;

    instDecoder decoder0 (
        .inst(instWord), .rs1Data(rs1Data), .rs2Data(rs2Data), .aluOp(aluOp),
        .opASel(opASel), .opBSel(opBSel), .regWen(regWen), .wbSel(wbSel),
        .loadSize(loadSize), .loadSigned(loadSigned), .storeSize(storeSize),
        .dataReadEn(readEn), .rs1to32(rs1to32), .csrWen(csrWen), .csrSet(csrSet),
        .isEcall(isEcall), .isMret(isMret), .isEbreak(isEbreak), .jumpReg(jumpReg),
        .takeTarget(takeTarget)
    );

    immGen immGen0 (.inst(instWord), .imm(imm));

    regFile regFile0 (
        .clk(clk), .rst(rst), .rs1Addr(instWord.fields.rs1), .rs2Addr(instWord.fields.rs2),
        .rdAddr(instWord.fields.rd), .rdWen(regWen & !halted), .rdData(wbData),
        .rs1Data(rs1Data), .rs2Data(rs2Data)
    );

    alu alu0 (.op(aluOp), .a(opA), .b(opB), .rs1to32(rs1to32), .result(aluResult));

    csrFile csrFile0 (
        .clk(clk), .rst(rst), .csrAddr(csrAddr), .wen(csrWen & !halted), .setBits(csrSet),
        .writeData(aluResult), .trap(isEcall & !halted), .trapPc(pc), .readData(csrRead),
        .mtvec(mtvec), .mepc(mepc)
    );

    loadStoreUnit lsu0 (
        .addr(aluResult), .storeData(rs2Data), .storeSize(storeSize), .loadSize(loadSize),
        .loadSigned(loadSigned), .memReadData(dataReadData), .writeData(dataWriteData),
        .writeMask(lsuMask), .loadData(loadData)
    );

endmodule

`default_nettype wire

// ==== sim/coreTb.sv ====
`default_nettype none

module coreTb;

    localparam int CLK_PERIOD = 40;
    localparam int DRIVE_DELAY = 5;
    localparam int MAX_PROG_WORDS = 72;
    localparam int TIMEOUT_CYCLES = 2 * MAX_PROG_WORDS + 4; // twice the program plus reset

    localparam logic [6:0] OPC_LOAD = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;
    localparam logic [6:0] OPC_IMM = 7'b0010011;
    localparam logic [6:0] OPC_REG = 7'b0110011;
    localparam logic [6:0] OPC_IMM32 = 7'b0011011;
    localparam logic [6:0] OPC_REG32 = 7'b0111011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL = 7'b1101111;
    localparam logic [6:0] OPC_JALR = 7'b1100111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    localparam logic [31:0] ECALL_WORD = 32'h0000_0073;
    localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;
    localparam logic [31:0] MRET_WORD = 32'h3020_0073;
    localparam logic [11:0] CSR_MTVEC = 12'h305;
    localparam logic [11:0] CSR_MEPC = 12'h341;
    localparam logic [11:0] CSR_MCAUSE = 12'h342;
    localparam logic [11:0] SKIP_ADDR = 12'h1f0; // only skipped paths store here

    logic        clk;
    logic        rst;
    logic [63:0] instAddr;
    logic [31:0] inst;
    logic [63:0] dataAddr;
    logic [63:0] dataWriteData;
    logic [7:0]  dataWriteMask;
    logic        dataReadEn;
    logic [63:0] dataReadData;
    logic        halted;

    logic [31:0] prog [128];
    logic [63:0] dataMem [64];
    logic [63:0] expData [64];
    logic [63:0] expLanes [64];
    logic [7:0]  expMask [64];
    int          seenCount [64];
    int          progLen;
    logic [63:0] nextAddr;
    logic [63:0] opA, opB;
    logic [5:0]  storeIdx;
    integer      seed;
    int          valueErrors;
    int          otherErrors;

    riscvCore #(.RESET_PC(64'd0)) dut0 (
        .clk(clk), .rst(rst), .instAddr(instAddr), .inst(inst), .dataAddr(dataAddr),
        .dataWriteData(dataWriteData), .dataWriteMask(dataWriteMask),
        .dataReadEn(dataReadEn), .dataReadData(dataReadData), .halted(halted)
    );

    // fetches past the program see ebreak
    assign inst = (instAddr < progLen * 4) ? prog[instAddr[8:2]] : EBREAK_WORD;
    assign storeIdx = dataAddr[8:3];
    assign dataReadData = dataMem[storeIdx];

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        for (int i = 0; i < 8; i++) begin
            if (dataWriteMask[i]) begin
                dataMem[storeIdx][8 * i +: 8] <= dataWriteData[8 * i +: 8];
            end
        end
    end

    always @(posedge clk) begin
        if (!rst && dataWriteMask != 8'h00) begin
            seenCount[storeIdx] <= seenCount[storeIdx] + 1;
        end
    end

    function automatic logic [31:0] rType(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] iType(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] sType(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] bType(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] jType(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    function automatic logic [63:0] signExtend32(input logic [31:0] value);
        return {{32{value[31]}}, value};
    endfunction

    task automatic emit(input logic [31:0] word);
        prog[progLen] = word;
        progLen++;
    endtask

    // data is given in its byte lanes
    task automatic expectStore(input logic [63:0] addr, input logic [63:0] data,
                               input logic [7:0] mask);
        logic [63:0] lanes;
        for (int i = 0; i < 8; i++) begin
            lanes[8 * i +: 8] = {8{mask[i]}};
        end
        expMask[addr[8:3]] = mask;
        expLanes[addr[8:3]] = lanes;
        expData[addr[8:3]] = data & lanes;
    endtask

    task automatic storeResult(input logic [4:0] rs2, input logic [63:0] expected);
        emit(sType(nextAddr[11:0], rs2, 5'd0, 3'b011)); // sd rs2, nextAddr(x0)
        expectStore(nextAddr, expected, 8'hff);
        nextAddr += 64'd8;
    endtask

    task automatic aluCheck(input logic [6:0] f7, input logic [2:0] f3, input logic [6:0] op,
                            input logic [63:0] expected);
        emit(rType(f7, 5'd2, 5'd1, f3, 5'd3, op)); // x3 = x1 op x2
        storeResult(5'd3, expected);
    endtask

    task automatic loadCheck(input logic [2:0] f3, input logic [11:0] addr,
                             input logic [63:0] expected);
        emit(iType(addr, 5'd0, f3, 5'd3, OPC_LOAD));
        storeResult(5'd3, expected);
    endtask

    task automatic setupMemories();
        for (int i = 0; i < 64; i++) begin
            dataMem[i] = 64'd0;
            expData[i] = 64'd0;
            expLanes[i] = 64'd0;
            expMask[i] = 8'h00;
            seenCount[i] = 0;
        end
        opA = {$random(seed), $random(seed)};
        opB = {$random(seed), $random(seed)};
        opA[63] = 1'b1; // signs differ so slt and sltu disagree
        opB[63] = 1'b0;
        opA[15] = 1'b1; // negative halfword for lh
        opB[7] = 1'b1;
        dataMem[0] = opA;
        dataMem[1] = opB;
        progLen = 0;
        nextAddr = 64'h10;
    endtask

    task automatic buildProgram();
        logic [63:0] jalAddr;
        logic [63:0] jalrAddr;
        logic [63:0] handlerAddr;
        logic [63:0] ecallAddr;
        emit(iType(12'h000, 5'd0, 3'b011, 5'd1, OPC_LOAD)); // ld x1, 0(x0)
        emit(iType(12'h008, 5'd0, 3'b011, 5'd2, OPC_LOAD)); // ld x2, 8(x0)
        aluCheck(7'h00, 3'b000, OPC_REG, opA + opB);
        aluCheck(7'h20, 3'b000, OPC_REG, opA - opB);
        aluCheck(7'h00, 3'b111, OPC_REG, opA & opB);
        aluCheck(7'h00, 3'b110, OPC_REG, opA | opB);
        aluCheck(7'h00, 3'b100, OPC_REG, opA ^ opB);
        aluCheck(7'h00, 3'b010, OPC_REG, {63'd0, $signed(opA) < $signed(opB)});
        aluCheck(7'h00, 3'b011, OPC_REG, {63'd0, opA < opB});
        aluCheck(7'h00, 3'b001, OPC_REG, opA << opB[5:0]);
        aluCheck(7'h00, 3'b101, OPC_REG, opA >> opB[5:0]);
        aluCheck(7'h20, 3'b101, OPC_REG, $signed(opA) >>> opB[5:0]);
        aluCheck(7'h00, 3'b000, OPC_REG32, signExtend32(opA[31:0] + opB[31:0]));
        aluCheck(7'h20, 3'b000, OPC_REG32, signExtend32(opA[31:0] - opB[31:0]));
        aluCheck(7'h00, 3'b101, OPC_REG32, signExtend32(opA[31:0] >> opB[4:0]));
        aluCheck(7'h20, 3'b101, OPC_REG32, signExtend32($signed(opA[31:0]) >>> opB[4:0]));
        emit(iType(12'd7, 5'd1, 3'b001, 5'd3, OPC_IMM32)); // slliw x3, x1, 7
        storeResult(5'd3, signExtend32(opA[31:0] << 7));

        // sub-word stores at nonzero offsets, then read back
        emit(sType(12'h103, 5'd2, 5'd0, 3'b000)); // sb x2, 0x103(x0)
        expectStore(64'h100, {56'd0, opB[7:0]} << 24, 8'h08);
        emit(sType(12'h10c, 5'd1, 5'd0, 3'b001)); // sh x1, 0x10c(x0)
        expectStore(64'h108, {48'd0, opA[15:0]} << 32, 8'h30);
        loadCheck(3'b000, 12'h103, {{56{opB[7]}}, opB[7:0]});
        loadCheck(3'b100, 12'h103, {56'd0, opB[7:0]});
        loadCheck(3'b001, 12'h10c, {{48{opA[15]}}, opA[15:0]});
        loadCheck(3'b101, 12'h10c, {48'd0, opA[15:0]});
        loadCheck(3'b010, 12'h004, {{32{opA[63]}}, opA[63:32]});

        emit(bType(13'd8, 5'd0, 5'd0, 3'b000)); // beq taken
        emit(sType(SKIP_ADDR, 5'd0, 5'd0, 3'b011));
        emit(bType(13'd8, 5'd2, 5'd1, 3'b100)); // blt taken, x1 negative
        emit(sType(SKIP_ADDR, 5'd0, 5'd0, 3'b011));
        emit(bType(13'd12, 5'd0, 5'd0, 3'b001)); // bne not taken
        emit(bType(13'd8, 5'd2, 5'd1, 3'b110)); // bltu not taken
        emit(iType(12'h05a, 5'd0, 3'b000, 5'd4, OPC_IMM));
        storeResult(5'd4, 64'h5a); // a wrongly taken branch skips the addi

        jalAddr = progLen * 4;
        emit(jType(21'd8, 5'd5)); // jal x5, +8
        emit(sType(SKIP_ADDR, 5'd0, 5'd0, 3'b011));
        storeResult(5'd5, jalAddr + 64'd4);
        jalrAddr = progLen * 4;
        emit(iType(12'd16, 5'd5, 3'b000, 5'd6, OPC_JALR)); // jalr x6, 16(x5)
        emit(sType(SKIP_ADDR, 5'd0, 5'd0, 3'b011));
        storeResult(5'd6, jalrAddr + 64'd4);

        handlerAddr = (progLen + 6) * 4;
        emit(iType(handlerAddr[11:0], 5'd0, 3'b000, 5'd7, OPC_IMM));
        emit(iType(CSR_MTVEC, 5'd7, 3'b001, 5'd0, OPC_SYSTEM)); // csrrw x0, mtvec, x7
        ecallAddr = progLen * 4;
        emit(ECALL_WORD);
        emit(iType(12'h077, 5'd0, 3'b000, 5'd8, OPC_IMM)); // return marker
        storeResult(5'd8, 64'h77);
        emit(EBREAK_WORD);

        // trap handler
        emit(iType(CSR_MCAUSE, 5'd0, 3'b010, 5'd9, OPC_SYSTEM)); // csrrs x9, mcause, x0
        storeResult(5'd9, 64'd11);
        emit(iType(CSR_MEPC, 5'd0, 3'b010, 5'd10, OPC_SYSTEM));
        storeResult(5'd10, ecallAddr);
        emit(iType(12'd4, 5'd10, 3'b000, 5'd10, OPC_IMM));
        emit(iType(CSR_MEPC, 5'd10, 3'b001, 5'd0, OPC_SYSTEM)); // mepc past the ecall
        emit(MRET_WORD);
    endtask

    task automatic checkStoreCounts();
        for (int i = 0; i < 64; i++) begin
            if (expMask[i] != 8'h00 && seenCount[i] != 1) begin
                otherErrors++;
                $display("store to address %h seen %0d times instead of once",
                         i * 8, seenCount[i]);
            end
        end
    endtask

    task automatic endRun();
        $display("errors: %0d wrong values, %0d other failures", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    storeIsExpected: assert property (@(posedge clk) disable iff (rst)
        dataWriteMask != 8'h00 |-> expMask[storeIdx] != 8'h00)
        else begin
            otherErrors++;
            $display("store at time %0t to address %h, which no executed path should reach",
                     $time, $sampled(dataAddr));
        end

    storeMaskCorrect: assert property (@(posedge clk) disable iff (rst)
        (dataWriteMask != 8'h00 && expMask[storeIdx] != 8'h00) |->
            dataWriteMask == expMask[storeIdx])
        else begin
            valueErrors++;
            $display("** Error at time %0t: dataWriteMask expected %h, got %h",
                     $time, expMask[$sampled(storeIdx)], $sampled(dataWriteMask));
        end

    storeDataCorrect: assert property (@(posedge clk) disable iff (rst)
        (dataWriteMask != 8'h00 && expMask[storeIdx] != 8'h00) |->
            (dataWriteData & expLanes[storeIdx]) == expData[storeIdx])
        else begin
            valueErrors++;
            $display("** Error at time %0t: dataWriteData expected %h, got %h",
                     $time, expData[$sampled(storeIdx)],
                     $sampled(dataWriteData) & expLanes[$sampled(storeIdx)]);
        end

    readEnOnLoads: assert property (@(posedge clk) disable iff (rst)
        !halted |-> dataReadEn == (inst[6:0] == OPC_LOAD))
        else begin
            valueErrors++;
            $display("** Error at time %0t: dataReadEn expected %b, got %b",
                     $time, $sampled(inst[6:0]) == OPC_LOAD, $sampled(dataReadEn));
        end

    haltHoldsPc: assert property (@(posedge clk) disable iff (rst) halted |-> $stable(instAddr))
        else begin
            valueErrors++;
            $display("** Error at time %0t: instAddr expected %h, got %h",
                     $time, $past(instAddr), $sampled(instAddr));
        end

    haltMasksStores: assert property (@(posedge clk) disable iff (rst)
        halted |-> dataWriteMask == 8'h00)
        else begin
            valueErrors++;
            $display("** Error at time %0t: dataWriteMask expected 00, got %h",
                     $time, $sampled(dataWriteMask));
        end

    haltBlocksReads: assert property (@(posedge clk) disable iff (rst)
        halted |-> !dataReadEn)
        else begin
            valueErrors++;
            $display("** Error at time %0t: dataReadEn expected 0, got %b",
                     $time, $sampled(dataReadEn));
        end

    initial begin
        rst = 1'b1;
        valueErrors = 0;
        otherErrors = 0;
        seed = 32'h11df_79ff;
        setupMemories();
        buildProgram();
        repeat (2) @(posedge clk);
        #DRIVE_DELAY rst = 1'b0;
        wait (halted === 1'b1);
        #DRIVE_DELAY;
        prog[instAddr[8:2]] = sType(SKIP_ADDR, 5'd8, 5'd0, 3'b011); // store under the frozen pc
        repeat (2) @(posedge clk);
        #DRIVE_DELAY;
        prog[instAddr[8:2]] = iType(12'h000, 5'd0, 3'b011, 5'd3, OPC_LOAD); // then a load
        repeat (2) @(posedge clk);
        #DRIVE_DELAY;
        checkStoreCounts();
        endRun();
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        otherErrors++;
        $display("watchdog: core never halted within %0d cycles", TIMEOUT_CYCLES);
        endRun();
    end

endmodule

`default_nettype wire
